/* include/nts_config.svh */
//--------------------------------------------------------------------
// NTS engine statistics configuration
// Bus widths, counter width and identity constants
//--------------------------------------------------------------------
`ifndef NTS_CONFIG_SVH
`define NTS_CONFIG_SVH

// Register bus geometry
`define NTS_API_ADDR_W   12
`define NTS_API_DATA_W   32
`define NTS_REG_ADDR_W   8
`define NTS_BLOCK_W      4

`define NTS_CNT_W        64
`define NTS_NUM_EVENTS   6

// Identity words, ASCII packed big endian
`define NTS_CORE_NAME0   32'h4e_54_53_5f // "NTS_"
`define NTS_CORE_NAME1   32'h45_4e_47_4e // "ENGN"
`define NTS_CORE_VERSION 32'h30_2e_30_32 // "0.02"
`define NTS_DEBUG_NAME   32'h44_42_55_47 // "DBUG"

`define NTS_SYSTICK_INIT 32'h0000_0001

`endif

/* hdl/nts_pkg.sv */
//--------------------------------------------------------------------
// NTS engine types: bus words, block codes and register offsets
//--------------------------------------------------------------------
`include "nts_config.svh"

package nts_pkg;

  typedef logic [`NTS_API_DATA_W-1:0] api_word_t;
  typedef logic [`NTS_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`NTS_CNT_W-1:0]      cnt_t;

  // Upper address nibble, other codes decode to nothing
  typedef enum logic [`NTS_BLOCK_W-1:0] {
    ENGINE = 4'h0,
    DEBUG  = 4'h2
  } api_block_e;

  typedef enum logic [`NTS_REG_ADDR_W-1:0] {
    NAME0   = 8'h00,
    NAME1   = 8'h01,
    VERSION = 8'h02,
    CTRL    = 8'h08
  } engine_reg_e;

  // Counter upper words; the snapshot sits at offset + 1
  typedef enum logic [`NTS_REG_ADDR_W-1:0] {
    PROCESSED    = 8'h00,
    BAD_COOKIE   = 8'h02,
    BAD_AUTH     = 8'h04,
    BAD_KEYID    = 8'h06,
    DBG_NAME     = 8'h08,
    SYSTICK      = 8'h09,
    ERROR_CRYPTO = 8'h20,
    ERROR_TXBUF  = 8'h22
  } debug_reg_e;

  typedef enum logic [2:0] {
    EVT_PROCESSED    = 3'd0,
    EVT_BAD_COOKIE   = 3'd1,
    EVT_BAD_AUTH     = 3'd2,
    EVT_BAD_KEYID    = 3'd3,
    EVT_ERROR_CRYPTO = 3'd4,
    EVT_ERROR_TXBUF  = 3'd5
  } event_idx_e;

endpackage

/* hdl/nts_api_if.sv */
//--------------------------------------------------------------------
// Internal register bus between the decoder and one block
//--------------------------------------------------------------------
`timescale 1ns/1ps

interface nts_api_if import nts_pkg::*; ();

  logic      cs;
  logic      we;
  reg_addr_t address;    // Offset inside the block
  api_word_t write_data;
  api_word_t read_data;  // Zero when not selected

  modport master (
    output cs,
    output we,
    output address,
    output write_data,
    input  read_data
  );

  modport slave (
    input  cs,
    input  we,
    input  address,
    input  write_data,
    output read_data
  );

endinterface

/* hdl/nts_api_decoder.sv */
//--------------------------------------------------------------------
// Register bus decoder
// Splits the address into block and offset, merges read data
//--------------------------------------------------------------------
`timescale 1ns/1ps

`include "nts_config.svh"

module nts_api_decoder
  import nts_pkg::*;
(
  input  logic                       i_cs,
  input  logic                       i_we,
  input  logic [`NTS_API_ADDR_W-1:0] i_address,
  input  api_word_t                  i_write_data,
  output api_word_t                  o_read_data,

  nts_api_if.master                  m_engine,
  nts_api_if.master                  m_debug
);

  api_block_e block;
  reg_addr_t  offset;

  assign block  = api_block_e'(i_address[`NTS_API_ADDR_W-1 -: `NTS_BLOCK_W]);
  assign offset = i_address[`NTS_REG_ADDR_W-1:0];

  //--------------------------------------------------------------------
  // Block selects
  //--------------------------------------------------------------------

  // Offset, strobe and data go to every block, only cs differs
  assign m_engine.we         = i_we;
  assign m_engine.address    = offset;
  assign m_engine.write_data = i_write_data;
  assign m_engine.cs         = i_cs && (block == ENGINE);

  assign m_debug.we          = i_we;
  assign m_debug.address     = offset;
  assign m_debug.write_data  = i_write_data;
  assign m_debug.cs          = i_cs && (block == DEBUG);

  //--------------------------------------------------------------------
  // Read data return
  //--------------------------------------------------------------------

  // Unselected blocks drive 0, so an OR is enough
  assign o_read_data = m_engine.read_data | m_debug.read_data;

endmodule

/* hdl/nts_engine_regs.sv */
//--------------------------------------------------------------------
// Engine identity block
// Core name, version and control word, all read only
//--------------------------------------------------------------------
`timescale 1ns/1ps

`include "nts_config.svh"

module nts_engine_regs
  import nts_pkg::*;
(
  nts_api_if.slave s_api
);

  api_word_t read_data;

  always_comb
  begin
    read_data = '0;
    if (s_api.cs && !s_api.we)
    begin
      case (s_api.address)
        NAME0:
          read_data = `NTS_CORE_NAME0;
        NAME1:
          read_data = `NTS_CORE_NAME1;
        VERSION:
          read_data = `NTS_CORE_VERSION;
        CTRL:
          read_data = 32'h0000_0001;  // Engine always enabled
        default:
          read_data = '0;
      endcase
    end
  end

  assign s_api.read_data = read_data;

endmodule

/* hdl/nts_debug_counter.sv */
//--------------------------------------------------------------------
// 64-bit event counter with a low-word snapshot register
//--------------------------------------------------------------------
`timescale 1ns/1ps

`include "nts_config.svh"

module nts_debug_counter
  import nts_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_areset,
  input  logic      i_event,     // One count per high edge
  input  logic      i_snapshot,  // Upper word is being read
  output cnt_t      o_count,
  output api_word_t o_snapshot
);

  cnt_t      count_reg;
  api_word_t snapshot_reg;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count_reg    <= '0;
      snapshot_reg <= '0;
    end
    else
    begin
      if (i_event)
        count_reg <= count_reg + 1'b1;

      // Pre-increment low word, matches the upper word just read
      if (i_snapshot)
        snapshot_reg <= count_reg[`NTS_API_DATA_W-1:0];
    end
  end

  assign o_count    = count_reg;
  assign o_snapshot = snapshot_reg;

endmodule

/* hdl/nts_debug_regs.sv */
//--------------------------------------------------------------------
// Debug block
// Six event counters, the system tick and their read decode
//--------------------------------------------------------------------
`timescale 1ns/1ps

`include "nts_config.svh"

module nts_debug_regs
  import nts_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic [`NTS_NUM_EVENTS-1:0] i_events,  // Indexed by event_idx_e
  nts_api_if.slave                  s_api
);

  cnt_t                       count [`NTS_NUM_EVENTS];
  api_word_t                  snapshot [`NTS_NUM_EVENTS];
  logic [`NTS_NUM_EVENTS-1:0] snap_req;
  api_word_t                  systick_reg;
  api_word_t                  read_data;

  // Upper-word offset of each counter
  function automatic reg_addr_t cnt_offset(input event_idx_e idx);
    case (idx)
      EVT_PROCESSED:    return PROCESSED;
      EVT_BAD_COOKIE:   return BAD_COOKIE;
      EVT_BAD_AUTH:     return BAD_AUTH;
      EVT_BAD_KEYID:    return BAD_KEYID;
      EVT_ERROR_CRYPTO: return ERROR_CRYPTO;
      EVT_ERROR_TXBUF:  return ERROR_TXBUF;
      default:          return '0;
    endcase
  endfunction

  //--------------------------------------------------------------------
  // Event counters
  //--------------------------------------------------------------------

  for (genvar g = 0; g < `NTS_NUM_EVENTS; g++)
  begin : g_cnt
    nts_debug_counter u_counter (
      .i_clk      (i_clk),
      .i_areset   (i_areset),
      .i_event    (i_events[g]),
      .i_snapshot (snap_req[g]),
      .o_count    (count[g]),
      .o_snapshot (snapshot[g])
    );
  end

  // Free-running tick
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      systick_reg <= `NTS_SYSTICK_INIT;
    else
      systick_reg <= systick_reg + 1'b1;
  end

  //--------------------------------------------------------------------
  // Read decode
  //--------------------------------------------------------------------

  always_comb
  begin
    read_data = '0;
    snap_req  = '0;
    if (s_api.cs && !s_api.we)
    begin
      for (int i = 0; i < `NTS_NUM_EVENTS; i++)
      begin
        if (s_api.address == cnt_offset(event_idx_e'(i)))
        begin
          read_data   = count[i][`NTS_CNT_W-1 -: `NTS_API_DATA_W];
          snap_req[i] = 1'b1;  // Low word latched on this edge
        end
        else if (s_api.address == cnt_offset(event_idx_e'(i)) + 8'd1)
        begin
          read_data = snapshot[i];
        end
      end

      case (s_api.address)
        DBG_NAME: read_data = `NTS_DEBUG_NAME;
        SYSTICK:  read_data = systick_reg;
        default:  ;
      endcase
    end
  end

  assign s_api.read_data = read_data;

endmodule

/* hdl/nts_engine_stats.sv */
//--------------------------------------------------------------------
// NTS engine register and statistics front end
// Bus decoder, identity block and debug counters
//--------------------------------------------------------------------
`timescale 1ns/1ps

`include "nts_config.svh"

module nts_engine_stats (
  input  logic                       i_clk,
  input  logic                       i_areset,

  input  logic                       i_api_cs,
  input  logic                       i_api_we,
  input  logic [`NTS_API_ADDR_W-1:0] i_api_address,
  input  logic [`NTS_API_DATA_W-1:0] i_api_write_data,
  output logic [`NTS_API_DATA_W-1:0] o_api_read_data,

  input  logic                       i_evt_nts_processed,
  input  logic                       i_evt_bad_cookie,
  input  logic                       i_evt_bad_auth,
  input  logic                       i_evt_bad_keyid,
  input  logic                       i_evt_error_crypto,
  input  logic                       i_evt_error_txbuf
);

  logic [`NTS_NUM_EVENTS-1:0] events;

  // Bit order follows the event index
  assign events = {i_evt_error_txbuf,
                   i_evt_error_crypto,
                   i_evt_bad_keyid,
                   i_evt_bad_auth,
                   i_evt_bad_cookie,
                   i_evt_nts_processed};

  nts_api_if api_engine ();
  nts_api_if api_debug ();

  //--------------------------------------------------------------------
  // Blocks
  //--------------------------------------------------------------------

  nts_api_decoder u_decoder (
    .i_cs         (i_api_cs),
    .i_we         (i_api_we),
    .i_address    (i_api_address),
    .i_write_data (i_api_write_data),
    .o_read_data  (o_api_read_data),
    .m_engine     (api_engine),
    .m_debug      (api_debug)
  );

  nts_engine_regs u_engine_regs (
    .s_api (api_engine)
  );

  nts_debug_regs u_debug_regs (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_events (events),
    .s_api    (api_debug)
  );

endmodule

/* testbench/nts_engine_assertions.sv */
//--------------------------------------------------------------------
// Bus, counter and tick assertions for the NTS engine statistics front end
//--------------------------------------------------------------------
`timescale 1ns/1ps

`include "nts_config.svh"

module nts_engine_assertions
  import nts_pkg::*;
(
  input logic                       i_clk,
  input logic                       i_areset,
  input logic                       i_api_cs,
  input logic                       i_api_we,
  input logic [`NTS_NUM_EVENTS-1:0] i_events,  // Indexed by event_idx_e
  input api_word_t                  i_read_data,
  input api_word_t                  i_systick,
  input cnt_t                       i_count [`NTS_NUM_EVENTS]
);

  int unsigned fail_count = 0;  // Failed assertions so far

  // No read access, no data on the bus
  assert property (@(posedge i_clk) disable iff (i_areset)
    (!i_api_cs || i_api_we) |-> (i_read_data == '0))
  else
  begin
    fail_count++;
    $error("Read data is not zero without a read access");
  end

  // First edge after release still holds the reset value
  assert property (@(posedge i_clk) disable iff (i_areset)
    !$past(i_areset) |-> (i_systick == $past(i_systick) + 32'd1))
  else
  begin
    fail_count++;
    $error("System tick did not advance by one");
  end

  for (genvar g = 0; g < `NTS_NUM_EVENTS; g++)
  begin : g_mono
    // Each strobe adds exactly one on its edge, so no counter goes down
    assert property (@(posedge i_clk) disable iff (i_areset)
      i_count[g] == $past(i_count[g]) + $past(i_events[g]))
    else
    begin
      fail_count++;
      $error("Event counter %0d did not follow its strobe", g);
    end
  end

endmodule

bind nts_engine_stats nts_engine_assertions u_assertions (
  .i_clk       (i_clk),
  .i_areset    (i_areset),
  .i_api_cs    (i_api_cs),
  .i_api_we    (i_api_we),
  .i_events    ({i_evt_error_txbuf,
                 i_evt_error_crypto,
                 i_evt_bad_keyid,
                 i_evt_bad_auth,
                 i_evt_bad_cookie,
                 i_evt_nts_processed}),
  .i_read_data (o_api_read_data),
  .i_systick   (u_debug_regs.systick_reg),
  .i_count     (u_debug_regs.count)
);

/* testbench/tb_nts_engine_stats.sv */
//--------------------------------------------------------------------
// Testbench for the NTS engine statistics front end
// Random event strobes, reference model and register bus checks
//--------------------------------------------------------------------
`timescale 1ns/1ps

`include "nts_config.svh"

module tb_nts_engine_stats
  import nts_pkg::*;
();

  localparam int SEED           = 69;
  localparam int RESET_CYCLES   = 3;
  localparam int EVENT_CYCLES   = 1000;
  localparam int TICK_GAP       = 37;
  localparam int TEST_CYCLES    = 2000;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  localparam api_word_t EXP_NAME0   = "NTS_";
  localparam api_word_t EXP_NAME1   = "ENGN";
  localparam api_word_t EXP_VERSION = "0.02";
  localparam api_word_t EXP_DBG     = "DBUG";

  // Counter upper-word offsets, in event order
  localparam reg_addr_t CNT_UPPER [`NTS_NUM_EVENTS] =
    '{8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22};

  logic                       i_clk;
  logic                       i_areset;
  logic                       i_api_cs;
  logic                       i_api_we;
  logic [`NTS_API_ADDR_W-1:0] i_api_address;
  api_word_t                  i_api_write_data;
  api_word_t                  o_api_read_data;
  logic [`NTS_NUM_EVENTS-1:0] evt;

  // Reference state
  cnt_t      ref_count [`NTS_NUM_EVENTS];
  api_word_t ref_snap [`NTS_NUM_EVENTS];
  api_word_t ref_tick;

  int   cycle_count = 0;
  int   release_cycle;
  logic events_on;

  nts_engine_stats UUT (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_api_cs            (i_api_cs),
    .i_api_we            (i_api_we),
    .i_api_address       (i_api_address),
    .i_api_write_data    (i_api_write_data),
    .o_api_read_data     (o_api_read_data),
    .i_evt_nts_processed (evt[EVT_PROCESSED]),
    .i_evt_bad_cookie    (evt[EVT_BAD_COOKIE]),
    .i_evt_bad_auth      (evt[EVT_BAD_AUTH]),
    .i_evt_bad_keyid     (evt[EVT_BAD_KEYID]),
    .i_evt_error_crypto  (evt[EVT_ERROR_CRYPTO]),
    .i_evt_error_txbuf   (evt[EVT_ERROR_TXBUF])
  );

  always #4 i_clk = ~i_clk;

  //--------------------------------------------------------------------
  // Checks and reference model
  //--------------------------------------------------------------------

  task automatic check_word(input api_word_t actual, input api_word_t expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s is 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_count(input cnt_t actual, input cnt_t expected, input string what);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic logic [`NTS_API_ADDR_W-1:0] debug_addr(input reg_addr_t off);
    return {DEBUG, off};
  endfunction

  function automatic logic [`NTS_API_ADDR_W-1:0] engine_addr(input reg_addr_t off);
    return {ENGINE, off};
  endfunction

  // Expected bus read value from the reference state
  function automatic api_word_t expected_read(input logic cs, input logic we,
                                              input logic [`NTS_API_ADDR_W-1:0] addr);
    logic [`NTS_BLOCK_W-1:0] blk;
    reg_addr_t               off;
    blk = addr[`NTS_API_ADDR_W-1 -: `NTS_BLOCK_W];
    off = addr[`NTS_REG_ADDR_W-1:0];
    if (!cs || we)
      return '0;  // Writes and idle cycles read 0
    if (blk == ENGINE)
    begin
      case (off)
        8'h00:   return EXP_NAME0;
        8'h01:   return EXP_NAME1;
        8'h02:   return EXP_VERSION;
        8'h08:   return 32'd1;
        default: return '0;
      endcase
    end
    if (blk != DEBUG)
      return '0;
    if (off == 8'h08)
      return EXP_DBG;
    if (off == 8'h09)
      return ref_tick;
    for (int i = 0; i < `NTS_NUM_EVENTS; i++)
    begin
      if (off == CNT_UPPER[i])
        return ref_count[i][63:32];
      if (off == CNT_UPPER[i] + 8'd1)
        return ref_snap[i];
    end
    return '0;
  endfunction

  always @(posedge i_clk)
  begin
    if (i_areset)
    begin
      ref_tick <= 32'd1;
      for (int i = 0; i < `NTS_NUM_EVENTS; i++)
      begin
        ref_count[i] <= '0;
        ref_snap[i]  <= '0;
      end
    end
    else
    begin
      ref_tick <= ref_tick + 32'd1;
      for (int i = 0; i < `NTS_NUM_EVENTS; i++)
      begin
        if (evt[i])
          ref_count[i] <= ref_count[i] + 64'd1;
        if (i_api_cs && !i_api_we && (i_api_address == debug_addr(CNT_UPPER[i])))
          ref_snap[i] <= ref_count[i][31:0];  // Low word before this edge
      end
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge i_clk)
  begin
    if (!i_areset)
      check_word(o_api_read_data, expected_read(i_api_cs, i_api_we, i_api_address),
                 $sformatf("read data at 0x%03h", i_api_address));
  end

  always @(posedge i_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // Random event strobes
  initial
  begin
    int unsigned rnd;
    rnd = $urandom(SEED);
    forever
    begin
      @(posedge i_clk);
      rnd = $urandom & $urandom;  // About one strobe in four
      if (events_on)
        evt <= rnd[`NTS_NUM_EVENTS-1:0];
      else
        evt <= '0;
    end
  end

  //--------------------------------------------------------------------
  // Bus tasks
  //--------------------------------------------------------------------

  task automatic bus_access(input logic we, input logic [`NTS_API_ADDR_W-1:0] addr,
                            input api_word_t wdata, output api_word_t data);
    @(posedge i_clk);
    i_api_cs         <= 1'b1;
    i_api_we         <= we;
    i_api_address    <= addr;
    i_api_write_data <= wdata;
    @(negedge i_clk);
    data = o_api_read_data;
  endtask

  task automatic bus_read(input logic [`NTS_API_ADDR_W-1:0] addr, output api_word_t data);
    bus_access(1'b0, addr, '0, data);
  endtask

  task automatic bus_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge i_clk);
      i_api_cs <= 1'b0;
      i_api_we <= 1'b0;
    end
  endtask

  // Upper word, optional gap, then snapshot
  task automatic read_counter(input int idx, input int gap, output cnt_t value);
    api_word_t upper;
    api_word_t lower;
    cnt_t      expected;
    bus_read(debug_addr(CNT_UPPER[idx]), upper);
    expected = ref_count[idx];
    if (gap > 0)
      bus_idle(gap);
    bus_read(debug_addr(CNT_UPPER[idx] + 8'd1), lower);
    value = {upper, lower};
    check_count(value, expected, $sformatf("counter %0d", idx));
  endtask

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------

  task automatic test_tick();
    api_word_t t0;
    api_word_t t1;
    api_word_t t2;
    bus_read(debug_addr(8'h09), t0);
    check_word(t0, api_word_t'(cycle_count - release_cycle + 1), "first tick");
    bus_read(debug_addr(8'h09), t1);
    bus_idle(TICK_GAP - 1);
    bus_read(debug_addr(8'h09), t2);
    check_word(t2 - t1, api_word_t'(TICK_GAP), "tick difference");
  endtask

  task automatic test_identity();
    api_word_t data;
    bus_read(engine_addr(8'h00), data);
    check_word(data, EXP_NAME0, "NAME0");
    bus_read(engine_addr(8'h01), data);
    check_word(data, EXP_NAME1, "NAME1");
    bus_read(engine_addr(8'h02), data);
    check_word(data, EXP_VERSION, "VERSION");
    bus_read(engine_addr(8'h08), data);
    check_word(data, 32'd1, "CTRL");
    bus_read(debug_addr(8'h08), data);
    check_word(data, EXP_DBG, "DBG_NAME");
    bus_read(engine_addr(8'h03), data);
    check_word(data, '0, "unused engine offset");
    bus_read(debug_addr(8'h10), data);
    check_word(data, '0, "unused debug offset");
    for (int b = 0; b < 16; b++)
    begin
      if (b != 0 && b != 2)
      begin
        bus_read({4'(b), 8'h08}, data);
        check_word(data, '0, $sformatf("unused block %0d", b));
      end
    end
  endtask

  task automatic test_counting();
    cnt_t value;
    events_on = 1'b1;
    bus_idle(EVENT_CYCLES);
    for (int i = 0; i < `NTS_NUM_EVENTS; i++)
      read_counter(i, 0, value);
    // Events keep running between the two reads
    for (int i = 0; i < `NTS_NUM_EVENTS; i++)
      read_counter(i, 5 + 3 * i, value);
  endtask

  task automatic test_writes();
    api_word_t snap_before [`NTS_NUM_EVENTS];
    cnt_t      count_before [`NTS_NUM_EVENTS];
    api_word_t data;
    cnt_t      value;
    events_on = 1'b1;
    bus_idle(50);  // Low words move past the last snapshot
    @(negedge i_clk);
    events_on = 1'b0;
    bus_idle(2);
    for (int i = 0; i < `NTS_NUM_EVENTS; i++)
    begin
      bus_read(debug_addr(CNT_UPPER[i] + 8'd1), snap_before[i]);
      count_before[i] = ref_count[i];
    end
    for (int i = 0; i < `NTS_NUM_EVENTS; i++)
    begin
      bus_access(1'b1, debug_addr(CNT_UPPER[i]), 32'hffff_ffff, data);
      check_word(data, '0, "write to upper word");
      bus_access(1'b1, debug_addr(CNT_UPPER[i] + 8'd1), 32'hffff_ffff, data);
      check_word(data, '0, "write to snapshot");
    end
    for (int i = 0; i < `NTS_NUM_EVENTS; i++)
    begin
      bus_read(debug_addr(CNT_UPPER[i] + 8'd1), data);
      check_word(data, snap_before[i], $sformatf("snapshot %0d after writes", i));
      read_counter(i, 0, value);
      check_count(value, count_before[i], $sformatf("counter %0d after writes", i));
    end
  endtask

  initial
  begin
    i_clk            = 1'b0;
    i_areset         = 1'b1;
    i_api_cs         = 1'b0;
    i_api_we         = 1'b0;
    i_api_address    = '0;
    i_api_write_data = '0;
    evt              = '0;
    events_on        = 1'b0;

    repeat (RESET_CYCLES) @(posedge i_clk);
    i_areset <= 1'b0;
    @(negedge i_clk);
    release_cycle = cycle_count;

    test_tick();
    test_identity();
    test_counting();
    test_writes();
    bus_idle(2);

    if (UUT.u_assertions.fail_count == 0)
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
    else
    begin
      $display("TESTBENCH FAILED");
      $fatal(1, "Bound assertions reported failures");
    end
  end

endmodule

/* build.f */
+incdir+include
hdl/nts_pkg.sv
hdl/nts_api_if.sv
hdl/nts_api_decoder.sv
hdl/nts_engine_regs.sv
hdl/nts_debug_counter.sv
hdl/nts_debug_regs.sv
hdl/nts_engine_stats.sv
testbench/nts_engine_assertions.sv
testbench/tb_nts_engine_stats.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the NTS engine statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_nts_engine_stats
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f build.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "Pass message found in $LOG"
  exit 0
else
  echo "Pass message missing from $LOG"
  exit 1
fi
